/* logic/lsu_cfg.svh */
`ifndef LSU_CFG_SVH
`define LSU_CFG_SVH

// queue entries
`define LSU_QDEPTH 8

// rob tag width, 16 tags
`define LSU_TAG_W 4

// data ram size in words, 256 bytes
`define LSU_RAM_WORDS 64

// cycles from req to resp
`define LSU_MEM_LAT 2

`endif

/* logic/lsu_pkg.sv */
`include "lsu_cfg.svh"

package lsu_pkg;

	typedef logic [31:0] word_t;
	typedef logic [`LSU_TAG_W-1:0] tag_t;
	typedef logic [2:0] funct3_t;
	typedef logic [3:0] lanes_t;

	typedef enum logic {
		acc_load,
		acc_store
	} acc_kind_t;

	typedef enum logic [1:0] {
		st_idle,
		st_wait,
		st_done
	} ctrl_state_t;

	// load funct3
	localparam funct3_t lb = 3'b000;
	localparam funct3_t lh = 3'b001;
	localparam funct3_t lw = 3'b010;
	localparam funct3_t lbu = 3'b100;
	localparam funct3_t lhu = 3'b101;

	// store funct3
	localparam funct3_t sb = 3'b000;
	localparam funct3_t sh = 3'b001;
	localparam funct3_t sw = 3'b010;

endpackage

/* logic/lsq_head_if.sv */
`timescale 1ns/1ps

interface lsq_head_if;
	import lsu_pkg::*;

	logic head_valid;
	acc_kind_t head_kind;
	funct3_t head_funct3;
	tag_t head_tag;
	word_t head_addr;
	word_t head_data;
	logic head_ready;
	// head went out to memory and was flushed since
	logic head_squashed;
	logic issue;
	logic deq;

	modport queue_side (
		output head_valid, head_kind, head_funct3, head_tag, head_addr, head_data,
		output head_ready, head_squashed,
		input issue, deq
	);

	modport ctrl_side (
		input head_valid, head_kind, head_funct3, head_tag, head_addr, head_data,
		input head_ready, head_squashed,
		output issue, deq
	);

endinterface

/* logic/dmem_if.sv */
`timescale 1ns/1ps

interface dmem_if;
	import lsu_pkg::*;

	logic req;
	logic we;
	lanes_t lanes;
	// word aligned
	word_t addr;
	word_t wdata;
	logic resp;
	word_t rdata;

	modport master (
		output req, we, lanes, addr, wdata,
		input resp, rdata
	);

	modport slave (
		input req, we, lanes, addr, wdata,
		output resp, rdata
	);

endinterface

/* logic/lsq_queue.sv */
`timescale 1ns/1ps
`include "lsu_cfg.svh"

module lsq_queue (
	input logic clk,
	input logic rst,
	input logic disp_valid,
	input lsu_pkg::acc_kind_t disp_kind,
	input lsu_pkg::funct3_t disp_funct3,
	input lsu_pkg::tag_t disp_tag,
	input lsu_pkg::word_t disp_base,
	input logic disp_base_is_tag,
	input lsu_pkg::word_t disp_data,
	input logic disp_data_is_tag,
	input lsu_pkg::word_t disp_imm,
	output logic disp_ready,
	input logic cdb_valid,
	input lsu_pkg::tag_t cdb_tag,
	input lsu_pkg::word_t cdb_data,
	input lsu_pkg::tag_t rob_head_tag,
	input logic flush_valid,
	input lsu_pkg::tag_t flush_tag,
	lsq_head_if.queue_side head
);
	import lsu_pkg::*;

	localparam int DEPTH = `LSU_QDEPTH;
	localparam int PW = $clog2(DEPTH);

	acc_kind_t e_kind [DEPTH];
	funct3_t e_funct3 [DEPTH];
	tag_t e_tag [DEPTH];
	word_t e_addr [DEPTH];
	word_t e_imm [DEPTH];
	logic e_base_pend [DEPTH];
	tag_t e_base_tag [DEPTH];
	word_t e_data [DEPTH];
	logic e_data_pend [DEPTH];
	tag_t e_data_tag [DEPTH];

	logic [PW-1:0] front, rear, front_n, rear_n, wr_slot;
	logic [PW:0] count, count_n, keep;
	logic squashed, squashed_n, inflight;
	logic enq, full;
	logic base_hit, data_hit;
	tag_t flush_age;
	logic [DEPTH-1:0] occupied;

	// distance from the rob head, wraps with the tag
	function automatic tag_t age_of(tag_t t, tag_t h);
		tag_t d;
		d = t - h;
		return d;
	endfunction

	assign full = (count == (PW+1)'(DEPTH));
	assign disp_ready = !full;
	assign flush_age = age_of(flush_tag, rob_head_tag);

	assign base_hit = disp_base_is_tag && cdb_valid && (cdb_tag == tag_t'(disp_base));
	assign data_hit = disp_data_is_tag && cdb_valid && (cdb_tag == tag_t'(disp_data));

	always_comb begin
		logic [PW-1:0] off;
		for (int i = 0; i < DEPTH; i++) begin
			off = PW'(i) - front;
			occupied[i] = ({1'b0, off} < count);
		end
	end

	// entries are in program order, so survivors form a prefix from the front
	always_comb begin : keep_scan
		logic [PW-1:0] slot;
		logic stop;
		keep = '0;
		stop = 1'b0;
		for (int i = 0; i < DEPTH; i++) begin
			slot = front + PW'(i);
			if (!stop && i < int'(count)) begin
				if ((i == 0 && squashed) || age_of(e_tag[slot], rob_head_tag) < flush_age)
					keep = keep + 1'b1;
				else
					stop = 1'b1;
			end
		end
	end

	always_comb begin
		front_n = front;
		rear_n = rear;
		count_n = count;
		squashed_n = squashed;
		enq = disp_valid && !full;
		if (flush_valid) begin
			enq = enq && (age_of(disp_tag, rob_head_tag) < flush_age);
			if (head.deq) begin
				front_n = front + 1'b1;
				count_n = (keep == '0) ? '0 : keep - 1'b1;
				squashed_n = 1'b0;
			end else if (keep == '0 && count != '0 && inflight) begin
				// response still due, hold the head slot until it returns
				count_n = {{PW{1'b0}}, 1'b1};
				squashed_n = 1'b1;
			end else begin
				count_n = keep;
			end
			rear_n = front_n + count_n[PW-1:0];
		end else if (head.deq) begin
			front_n = front + 1'b1;
			count_n = count - 1'b1;
			squashed_n = 1'b0;
		end
		wr_slot = rear_n;
		if (enq) begin
			rear_n = rear_n + 1'b1;
			count_n = count_n + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			front <= '0;
			rear <= '0;
			count <= '0;
			squashed <= 1'b0;
			inflight <= 1'b0;
		end else begin
			front <= front_n;
			rear <= rear_n;
			count <= count_n;
			squashed <= squashed_n;
			if (head.deq)
				inflight <= 1'b0;
			else if (head.issue)
				inflight <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		// bus snoop
		for (int i = 0; i < DEPTH; i++) begin
			if (occupied[i] && cdb_valid) begin
				if (e_base_pend[i] && e_base_tag[i] == cdb_tag) begin
					e_addr[i] <= cdb_data + e_imm[i];
					e_base_pend[i] <= 1'b0;
				end
				if (e_data_pend[i] && e_data_tag[i] == cdb_tag) begin
					e_data[i] <= cdb_data;
					e_data_pend[i] <= 1'b0;
				end
			end
		end
		if (enq) begin
			e_kind[wr_slot] <= disp_kind;
			e_funct3[wr_slot] <= disp_funct3;
			e_tag[wr_slot] <= disp_tag;
			e_imm[wr_slot] <= disp_imm;
			e_base_tag[wr_slot] <= tag_t'(disp_base);
			e_data_tag[wr_slot] <= tag_t'(disp_data);
			e_addr[wr_slot] <= (base_hit ? cdb_data : disp_base) + disp_imm;
			e_base_pend[wr_slot] <= disp_base_is_tag && !base_hit;
			e_data[wr_slot] <= data_hit ? cdb_data : disp_data;
			e_data_pend[wr_slot] <= disp_data_is_tag && !data_hit;
		end
	end

	assign head.head_valid = (count != '0);
	assign head.head_kind = e_kind[front];
	assign head.head_funct3 = e_funct3[front];
	assign head.head_tag = e_tag[front];
	assign head.head_addr = e_addr[front];
	assign head.head_data = e_data[front];
	assign head.head_squashed = squashed || (flush_valid && inflight && keep == '0);

	// stores wait for the rob head so they are never speculative
	assign head.head_ready = head.head_valid && !squashed && !flush_valid
		&& !e_base_pend[front]
		&& (e_kind[front] == acc_load
			|| (!e_data_pend[front] && e_tag[front] == rob_head_tag));

endmodule

/* logic/lsu_align.sv */
`timescale 1ns/1ps

module lsu_align (
	input lsu_pkg::acc_kind_t kind,
	input lsu_pkg::funct3_t funct3,
	input logic [1:0] byte_addr,
	input lsu_pkg::word_t wdata,
	input lsu_pkg::word_t rdata,
	output lsu_pkg::lanes_t lanes,
	output lsu_pkg::word_t wdata_shifted,
	output lsu_pkg::word_t load_value
);
	import lsu_pkg::*;

	logic [4:0] shamt;
	word_t rdata_shifted;

	assign shamt = {byte_addr, 3'b000};
	assign wdata_shifted = wdata << shamt;
	assign rdata_shifted = rdata >> shamt;

	// loads read the whole word
	always_comb begin
		lanes = 4'b1111;
		if (kind == acc_store) begin
			case (funct3)
				sb: lanes = 4'b0001 << byte_addr;
				sh: lanes = 4'b0011 << byte_addr;
				sw: lanes = 4'b1111;
				default: lanes = 4'b1111;
			endcase
		end
	end

	always_comb begin
		case (funct3)
			lb: load_value = {{24{rdata_shifted[7]}}, rdata_shifted[7:0]};
			lh: load_value = {{16{rdata_shifted[15]}}, rdata_shifted[15:0]};
			lw: load_value = rdata_shifted;
			lbu: load_value = {24'd0, rdata_shifted[7:0]};
			lhu: load_value = {16'd0, rdata_shifted[15:0]};
			default: load_value = rdata_shifted;
		endcase
	end

endmodule

/* logic/lsq_mem_ctrl.sv */
`timescale 1ns/1ps

module lsq_mem_ctrl (
	input logic clk,
	input logic rst,
	lsq_head_if.ctrl_side head,
	dmem_if.master mem,
	output logic res_valid,
	output lsu_pkg::tag_t res_tag,
	output lsu_pkg::word_t res_data
);
	import lsu_pkg::*;

	ctrl_state_t state;
	logic req;
	acc_kind_t cur_kind;
	funct3_t cur_funct3;
	tag_t cur_tag;
	word_t cur_addr;
	word_t cur_data;
	lanes_t lanes;
	word_t wdata_shifted;
	word_t load_value;

	lsu_align u_align (
		.kind (cur_kind),
		.funct3 (cur_funct3),
		.byte_addr (cur_addr[1:0]),
		.wdata (cur_data),
		.rdata (mem.rdata),
		.lanes (lanes),
		.wdata_shifted (wdata_shifted),
		.load_value (load_value)
	);

	assign head.issue = (state == st_idle) && head.head_valid && head.head_ready;
	assign head.deq = (state == st_wait) && mem.resp;

	assign mem.req = req;
	assign mem.we = (cur_kind == acc_store);
	assign mem.lanes = lanes;
	assign mem.addr = {cur_addr[31:2], 2'b00};
	assign mem.wdata = wdata_shifted;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= st_idle;
			req <= 1'b0;
			res_valid <= 1'b0;
		end else begin
			res_valid <= 1'b0;
			case (state)
				st_idle: begin
					if (head.issue) begin
						req <= 1'b1;
						state <= st_wait;
					end
				end
				st_wait: begin
					if (mem.resp) begin
						req <= 1'b0;
						// flushed while in flight, nothing to report
						res_valid <= !head.head_squashed;
						state <= st_done;
					end
				end
				st_done: state <= st_idle;
				default: state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (head.issue) begin
			cur_kind <= head.head_kind;
			cur_funct3 <= head.head_funct3;
			cur_tag <= head.head_tag;
			cur_addr <= head.head_addr;
			cur_data <= head.head_data;
		end
		if (head.deq) begin
			res_tag <= cur_tag;
			res_data <= (cur_kind == acc_load) ? load_value : cur_data;
		end
	end

endmodule

/* logic/data_ram.sv */
`timescale 1ns/1ps
`include "lsu_cfg.svh"

module data_ram (
	input logic clk,
	input logic rst,
	dmem_if.slave mem
);
	import lsu_pkg::*;

	localparam int WORDS = `LSU_RAM_WORDS;
	localparam int AW = $clog2(WORDS);
	localparam int CW = $clog2(`LSU_MEM_LAT + 1);

	word_t ram [WORDS];
	logic busy;
	logic [CW-1:0] cnt;
	logic [AW-1:0] idx;
	word_t rdata_q;

	// byte address wraps at the ram size
	assign idx = mem.addr[AW+1:2];
	assign mem.resp = busy && (cnt == '0);
	assign mem.rdata = rdata_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= 1'b0;
			cnt <= '0;
			for (int i = 0; i < WORDS; i++)
				ram[i] <= '0;
		end else if (busy) begin
			if (cnt == '0)
				busy <= 1'b0;
			else
				cnt <= cnt - 1'b1;
		end else if (mem.req) begin
			busy <= 1'b1;
			cnt <= CW'(`LSU_MEM_LAT - 1);
			rdata_q <= ram[idx];
			if (mem.we) begin
				for (int b = 0; b < 4; b++) begin
					if (mem.lanes[b])
						ram[idx][8*b +: 8] <= mem.wdata[8*b +: 8];
				end
			end
		end
	end

endmodule

/* logic/load_store_unit.sv */
`timescale 1ns/1ps

module load_store_unit (
	input logic clk,
	input logic rst,
	input logic disp_valid,
	input lsu_pkg::acc_kind_t disp_kind,
	input lsu_pkg::funct3_t disp_funct3,
	input lsu_pkg::tag_t disp_tag,
	input lsu_pkg::word_t disp_base,
	input logic disp_base_is_tag,
	input lsu_pkg::word_t disp_data,
	input logic disp_data_is_tag,
	input lsu_pkg::word_t disp_imm,
	output logic disp_ready,
	input logic cdb_valid,
	input lsu_pkg::tag_t cdb_tag,
	input lsu_pkg::word_t cdb_data,
	input lsu_pkg::tag_t rob_head_tag,
	input logic flush_valid,
	input lsu_pkg::tag_t flush_tag,
	output logic res_valid,
	output lsu_pkg::tag_t res_tag,
	output lsu_pkg::word_t res_data
);

	lsq_head_if head_bus ();
	dmem_if mem_bus ();

	lsq_queue u_queue (
		.clk (clk),
		.rst (rst),
		.disp_valid (disp_valid),
		.disp_kind (disp_kind),
		.disp_funct3 (disp_funct3),
		.disp_tag (disp_tag),
		.disp_base (disp_base),
		.disp_base_is_tag (disp_base_is_tag),
		.disp_data (disp_data),
		.disp_data_is_tag (disp_data_is_tag),
		.disp_imm (disp_imm),
		.disp_ready (disp_ready),
		.cdb_valid (cdb_valid),
		.cdb_tag (cdb_tag),
		.cdb_data (cdb_data),
		.rob_head_tag (rob_head_tag),
		.flush_valid (flush_valid),
		.flush_tag (flush_tag),
		.head (head_bus.queue_side)
	);

	lsq_mem_ctrl u_ctrl (
		.clk (clk),
		.rst (rst),
		.head (head_bus.ctrl_side),
		.mem (mem_bus.master),
		.res_valid (res_valid),
		.res_tag (res_tag),
		.res_data (res_data)
	);

	data_ram u_ram (
		.clk (clk),
		.rst (rst),
		.mem (mem_bus.slave)
	);

endmodule

/* test/load_store_unit_chk.sv */
`timescale 1ns/1ps

module load_store_unit_chk (
	input logic clk,
	input logic rst,
	input logic res_valid,
	input logic disp_ready,
	input logic req,
	input logic we,
	input logic [3:0] lanes,
	input logic resp
);

	a_write_lanes: assert property (@(posedge clk) disable iff (rst)
		(req && we) |-> (lanes != 4'b0000))
		else $error("ram write with no byte lanes");

	a_res_pulse: assert property (@(posedge clk) disable iff (rst)
		res_valid |=> !res_valid)
		else $error("res_valid high two cycles in a row");

	a_ready_after_reset: assert property (@(posedge clk) $fell(rst) |-> disp_ready)
		else $error("disp_ready low after reset");

	// one request at a time, resp only while it is held
	a_resp_with_req: assert property (@(posedge clk) disable iff (rst)
		resp |-> req)
		else $error("resp without a request");

	a_one_resp: assert property (@(posedge clk) disable iff (rst)
		resp |=> !resp)
		else $error("two responses for one request");

endmodule

bind load_store_unit load_store_unit_chk u_chk (
	.clk (clk),
	.rst (rst),
	.res_valid (res_valid),
	.disp_ready (disp_ready),
	.req (mem_bus.req),
	.we (mem_bus.we),
	.lanes (mem_bus.lanes),
	.resp (mem_bus.resp)
);

/* test/load_store_unit_tb.sv */
`timescale 1ns/1ps

module load_store_unit_tb;
	import lsu_pkg::*;

	typedef struct {
		acc_kind_t kind;
		funct3_t f3;
		tag_t tag;
		word_t base;
		logic bpend;
		word_t data;
		logic dpend;
		word_t imm;
	} exp_op_t;

	// cycles the rob head trails the oldest unresolved op
	localparam int RETIRE_LAG = 8;

	logic clk, rst;
	logic disp_valid, disp_base_is_tag, disp_data_is_tag, disp_ready;
	acc_kind_t disp_kind;
	funct3_t disp_funct3;
	tag_t disp_tag, cdb_tag, rob_head_tag, flush_tag, res_tag;
	word_t disp_base, disp_data, disp_imm, cdb_data, res_data;
	logic cdb_valid, flush_valid, res_valid;

	exp_op_t exp_q[$];
	logic [7:0] img [256];
	int errors = 0;
	int cycles = 0;
	int limit = 0;
	int retire_wait = 0;

	load_store_unit DUT (.*);

	initial clk = 1'b0;
	always #20 clk = ~clk;

	task automatic check_eq(input word_t got, input word_t exp, input string what);
		if (got !== exp) begin
			errors++;
			$display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	function automatic word_t load_expect(funct3_t f3, logic [7:0] a);
		logic [7:0] wb;
		wb = {a[7:2], 2'b00};
		case (f3)
			lb: return {{24{img[a][7]}}, img[a]};
			lh: return {{16{img[a+8'd1][7]}}, img[a+8'd1], img[a]};
			lbu: return {24'd0, img[a]};
			lhu: return {16'd0, img[a+8'd1], img[a]};
			default: return {img[wb+8'd3], img[wb+8'd2], img[wb+8'd1], img[wb]};
		endcase
	endfunction

	task automatic check_result(input exp_op_t e);
		logic [7:0] a;
		word_t addr;
		addr = e.base + e.imm;
		a = addr[7:0];
		check_eq(word_t'(res_tag), word_t'(e.tag), "result tag");
		if (e.bpend || (e.kind == acc_store && e.dpend)) begin
			errors++;
			$display("tag %0d completed before its operand was broadcast", e.tag);
		end
		if (e.kind == acc_store) begin
			check_eq(word_t'(rob_head_tag), word_t'(e.tag), "rob head at store");
			check_eq(res_data, e.data, "store data");
			// little endian byte image
			case (e.f3)
				sb: img[a] = e.data[7:0];
				sh: {img[a+8'd1], img[a]} = e.data[15:0];
				default: {img[a+8'd3], img[a+8'd2], img[a+8'd1], img[a]} = e.data;
			endcase
		end else begin
			check_eq(res_data, load_expect(e.f3, a), "load value");
		end
	endtask

	always @(negedge clk) begin : result_monitor
		exp_op_t e;
		if (!rst && res_valid) begin
			if (exp_q.size() == 0) begin
				errors++;
				$display("result for tag %0d arrived with nothing outstanding", res_tag);
			end else begin
				e = exp_q.pop_front();
				check_result(e);
			end
		end
	end

	// rob head moves to the oldest unresolved op some cycles after the last one retires
	always @(posedge clk) begin
		#1;
		if (exp_q.size() != 0 && exp_q[0].tag != rob_head_tag) begin
			if (retire_wait >= RETIRE_LAG) begin
				rob_head_tag = exp_q[0].tag;
				retire_wait = 0;
			end else begin
				retire_wait++;
			end
		end else begin
			retire_wait = 0;
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (limit != 0 && cycles > limit) begin
			$display("timeout after %0d cycles, results still outstanding", limit);
			$display("test failed");
			$finish;
		end
	end

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge clk);
			#2;
		end
	endtask

	task automatic do_dispatch(input word_t k, f3, t, b, bt, d, dt, imm);
		exp_op_t e;
		disp_valid = 1'b1;
		disp_kind = acc_kind_t'(k[0]);
		disp_funct3 = funct3_t'(f3);
		disp_tag = tag_t'(t);
		disp_base = b;
		disp_base_is_tag = bt[0];
		disp_data = d;
		disp_data_is_tag = dt[0];
		disp_imm = imm;
		while (!disp_ready)
			idle_cycles(1);
		@(posedge clk);
		e = '{disp_kind, disp_funct3, disp_tag, b, bt[0], d, dt[0], imm};
		exp_q.push_back(e);
		#2;
		disp_valid = 1'b0;
		idle_cycles(1 + $urandom % 3);
	endtask

	task automatic do_broadcast(input word_t t, input word_t d);
		foreach (exp_q[i]) begin
			if (exp_q[i].bpend && tag_t'(exp_q[i].base) == tag_t'(t)) begin
				exp_q[i].base = d;
				exp_q[i].bpend = 1'b0;
			end
			if (exp_q[i].dpend && tag_t'(exp_q[i].data) == tag_t'(t)) begin
				exp_q[i].data = d;
				exp_q[i].dpend = 1'b0;
			end
		end
		cdb_valid = 1'b1;
		cdb_tag = tag_t'(t);
		cdb_data = d;
		idle_cycles(1);
		cdb_valid = 1'b0;
	endtask

	task automatic do_flush(input word_t t);
		tag_t fage;
		fage = tag_t'(t) - rob_head_tag;
		for (int i = exp_q.size() - 1; i >= 0; i--) begin
			if (tag_t'(exp_q[i].tag - rob_head_tag) >= fage)
				exp_q.delete(i);
		end
		flush_valid = 1'b1;
		flush_tag = tag_t'(t);
		idle_cycles(1);
		flush_valid = 1'b0;
	endtask

	initial begin : stimulus
		int fd, n;
		string line;
		word_t a0, a1, a2, a3, a4, a5, a6, a7;
		int wn;
		void'($urandom(53));
		rst = 1'b1;
		disp_valid = 1'b0;
		disp_kind = acc_load;
		disp_funct3 = '0;
		disp_tag = '0;
		disp_base = '0;
		disp_base_is_tag = 1'b0;
		disp_data = '0;
		disp_data_is_tag = 1'b0;
		disp_imm = '0;
		cdb_valid = 1'b0;
		cdb_tag = '0;
		cdb_data = '0;
		rob_head_tag = '0;
		flush_valid = 1'b0;
		flush_tag = '0;
		foreach (img[i])
			img[i] = 8'h00;
		fd = $fopen("test/lsu_input.txt", "r");
		if (fd == 0) begin
			$display("cannot open test/lsu_input.txt");
			$display("test failed");
			$finish;
		end else begin
			n = 0;
			while ($fgets(line, fd) != 0)
				n++;
			$fclose(fd);
			limit = 20 * n + 100;
			fd = $fopen("test/lsu_input.txt", "r");
			repeat (2) @(posedge clk);
			#2;
			rst = 1'b0;
			while ($fgets(line, fd) != 0) begin
				if (line.len() < 2 || line.getc(0) == "#")
					continue;
				case (line.getc(0))
					"d": begin
						void'($sscanf(line, "d %h %h %h %h %h %h %h %h",
							a0, a1, a2, a3, a4, a5, a6, a7));
						do_dispatch(a0, a1, a2, a3, a4, a5, a6, a7);
					end
					"b": begin
						void'($sscanf(line, "b %h %h", a0, a1));
						do_broadcast(a0, a1);
					end
					"f": begin
						void'($sscanf(line, "f %h", a0));
						do_flush(a0);
					end
					"w": begin
						void'($sscanf(line, "w %d", wn));
						idle_cycles(wn);
					end
					"r": begin
						void'($sscanf(line, "r %h", a0));
						check_eq(word_t'(disp_ready), a0, "disp_ready");
					end
					default: begin
						errors++;
						$display("unknown command in input file: %s", line);
					end
				endcase
			end
			$fclose(fd);
			while (exp_q.size() != 0)
				@(posedge clk);
			repeat (5) @(posedge clk);
			$display("errors: %0d", errors);
			if (errors == 0)
				$display("test passed");
			else
				$display("test failed");
			$finish;
		end
	end

endmodule

/* test/lsu_input.txt */
# d kind funct3 tag base base_is_tag data data_is_tag imm (hex), b tag data (hex)
# f tag (hex), w cycles (decimal), r expected disp_ready
d 1 2 0 20 0 8badf00d 0 0
d 1 0 1 40 0 a5 0 1
d 1 1 2 40 0 c381 0 2
d 1 0 3 40 0 7f 0 0
d 0 2 4 40 0 0 0 0
d 0 0 5 40 0 0 0 1
d 0 4 6 40 0 0 0 1
d 0 1 7 40 0 0 0 2
d 0 5 8 40 0 0 0 2
d 0 0 9 20 0 0 0 3
w 10
d 0 2 a f 1 0 0 4
d 1 2 b 20 0 e 1 8
w 4
b f 1c
b e 12345678
w 20
d 1 2 c 60 0 4 1 0
d 0 2 d 60 0 0 0 0
d 0 2 e 60 0 0 0 0
d 0 2 f 60 0 0 0 0
d 0 2 0 60 0 0 0 0
d 0 2 1 60 0 0 0 0
d 0 2 2 60 0 0 0 0
d 0 2 3 60 0 0 0 0
r 0
b 4 cafe0001
w 60
r 1
d 0 2 4 60 0 0 0 0
w 10
d 0 2 5 28 0 0 0 0
w 10
d 0 2 6 9 1 0 0 0
d 1 0 7 40 0 11 0 0
d 0 0 8 40 0 0 0 0
f 7
b 9 20
w 10
d 0 2 7 20 0 0 0 0
f 7
w 10
d 0 4 7 40 0 0 0 0
d 1 2 8 44 0 55aa 0 0
d 0 2 9 44 0 0 0 0
w 10

/* load_store_unit.f */
+incdir+logic
logic/lsu_pkg.sv
logic/lsq_head_if.sv
logic/dmem_if.sv
logic/lsq_queue.sv
logic/lsu_align.sv
logic/lsq_mem_ctrl.sv
logic/data_ram.sv
logic/load_store_unit.sv
test/load_store_unit_chk.sv
test/load_store_unit_tb.sv

/* run.sh */
#!/bin/bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module load_store_unit_tb -f load_store_unit.f -o sim_lsu

./obj_dir/sim_lsu | tee sim.log

grep -q "^test passed$" sim.log
